//--- hdl/ising_cfg_pkg.sv
/*
 * Ising annealer configuration
 * Sizes of the spin vector, field weights, energies, energy FIFO and step counter
 */

package ising_cfg_pkg;

    // Spin positions per candidate, one word
    localparam int num_spin_c = 16;
    // Signed local field per spin
    localparam int field_bit_c = 8;
    // Signed total energy, wide enough for num_spin_c full-scale fields
    localparam int energy_bit_c = 16;
    localparam int fifo_depth_c = 2;
    localparam int count_bit_c = 8;

endpackage

//--- hdl/ising_types_pkg.sv
/*
 * Ising annealer types
 * Step controller states and the energy ceiling used as the initial best
 */

package ising_types_pkg;

    // Candidate intake, serial accumulation, best compare, output hold
    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        COMPARE,
        HOLD
    } step_state_t;

    // Largest positive energy, so any real candidate beats it
    localparam logic signed [ising_cfg_pkg::energy_bit_c-1:0] energy_max_c =
        {1'b0, {(ising_cfg_pkg::energy_bit_c-1){1'b1}}};

endpackage

//--- hdl/spin_stream_if.sv
/*
 * Spin stream link
 * Candidate spin and its energy, each with its own valid/ready pair
 */

`timescale 1ns/1ps

interface spin_stream_if #(
    parameter int NUM_SPIN = ising_cfg_pkg::num_spin_c
);
    import ising_cfg_pkg::*;

    // Spin channel
    logic valid;
    logic ready;
    logic [NUM_SPIN-1:0] spin;
    // Energy channel, offered once accumulation is complete
    logic energy_valid;
    logic energy_ready;
    logic signed [energy_bit_c-1:0] energy;

    modport src (output valid, spin, energy_valid, energy, input ready, energy_ready);
    modport dst (input valid, spin, energy_valid, energy, output ready, energy_ready);

endinterface

//--- hdl/field_mem.sv
/*
 * Local field memory
 * One signed weight per spin position, host written, read combinationally by index
 */

`timescale 1ns/1ps

module field_mem #(
    parameter int NUM_SPIN = ising_cfg_pkg::num_spin_c,
    parameter int unsigned IDX_BIT = (NUM_SPIN > 1) ? $clog2(NUM_SPIN) : 1
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic we_i,
    input  logic [IDX_BIT-1:0] waddr_i,
    input  logic signed [ising_cfg_pkg::field_bit_c-1:0] wdata_i,
    input  logic [IDX_BIT-1:0] raddr_i,
    output logic signed [ising_cfg_pkg::field_bit_c-1:0] rdata_o
);
    import ising_cfg_pkg::*;

    logic signed [field_bit_c-1:0] mem_q [NUM_SPIN];

    // Single-cycle write, visible from the next edge on
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_q <= '{default: '0};
        end else if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle read for the accumulator
    assign rdata_o = mem_q[raddr_i];

endmodule

//--- hdl/energy_accum.sv
/*
 * Serial energy accumulator
 * Walks all spin positions, one per cycle, adding the field of set spins
 * and subtracting the field of clear spins
 */

`timescale 1ns/1ps

module energy_accum #(
    parameter int NUM_SPIN = ising_cfg_pkg::num_spin_c,
    parameter int unsigned IDX_BIT = (NUM_SPIN > 1) ? $clog2(NUM_SPIN) : 1
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic start_i,
    input  logic [NUM_SPIN-1:0] spin_i,
    output logic [IDX_BIT-1:0] field_addr_o,
    input  logic signed [ising_cfg_pkg::field_bit_c-1:0] field_i,
    output logic done_o,
    output logic signed [ising_cfg_pkg::energy_bit_c-1:0] energy_o
);
    import ising_cfg_pkg::*;

    logic busy_q;
    logic done_q;
    logic [IDX_BIT-1:0] idx_q;
    logic [NUM_SPIN-1:0] spin_q;
    logic signed [energy_bit_c-1:0] sum_q;
    logic signed [energy_bit_c-1:0] field_ext;

    // Sign extension of the addressed weight
    assign field_ext = field_i;
    assign field_addr_o = idx_q;

    // Start restarts the walk even if one is running
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            idx_q <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            idx_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (busy_q) begin
                if (idx_q == IDX_BIT'(NUM_SPIN - 1)) begin
                    busy_q <= 1'b0;
                    // One-cycle pulse right after the last position
                    done_q <= 1'b1;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    // Spin snapshot and running sum, held after the walk
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            spin_q <= spin_i;
            sum_q <= '0;
        end else if (busy_q) begin
            sum_q <= spin_q[idx_q] ? sum_q + field_ext : sum_q - field_ext;
        end
    end

    assign done_o = done_q;
    assign energy_o = sum_q;

endmodule

//--- hdl/energy_fifo.sv
/*
 * Energy FIFO
 * Circular store of energies; reset and flush seed one entry with the
 * energy ceiling, push-none writes the popped head back instead of new data
 */

`timescale 1ns/1ps

module energy_fifo #(
    parameter int unsigned FIFO_DEPTH = ising_cfg_pkg::fifo_depth_c,
    parameter int unsigned ADDR_DEPTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic flush_i,
    input  logic push_i,
    input  logic pop_i,
    input  logic push_none_i,
    input  logic signed [ising_cfg_pkg::energy_bit_c-1:0] data_i,
    output logic signed [ising_cfg_pkg::energy_bit_c-1:0] data_o,
    output logic full_o,
    output logic empty_o,
    output logic [ADDR_DEPTH-1:0] usage_o
);
    import ising_cfg_pkg::*;
    import ising_types_pkg::*;

    logic signed [energy_bit_c-1:0] mem_q [FIFO_DEPTH];
    logic signed [energy_bit_c-1:0] wr_data;
    logic [ADDR_DEPTH-1:0] rd_ptr_q;
    logic [ADDR_DEPTH-1:0] wr_ptr_q;
    // One bit wider than the pointers so full is distinct from empty
    logic [ADDR_DEPTH:0] cnt_q;
    logic do_push;
    logic do_pop;

    // Wrap at FIFO_DEPTH, which need not be a power of two
    function automatic logic [ADDR_DEPTH-1:0] next_ptr(input logic [ADDR_DEPTH-1:0] ptr);
        return (ptr == ADDR_DEPTH'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign data_o = mem_q[rd_ptr_q];
    assign full_o = (cnt_q == (ADDR_DEPTH + 1)'(FIFO_DEPTH));
    assign empty_o = (cnt_q == '0);
    assign usage_o = cnt_q[ADDR_DEPTH-1:0];
    assign do_pop = pop_i & ~empty_o;
    // A pop in the same cycle frees the slot for the push
    assign do_push = push_i & (~full_o | do_pop);
    // Keep the stored best when the candidate did not improve
    assign wr_data = push_none_i ? data_o : data_i;

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= next_ptr('0);
            cnt_q <= 1;
        end else begin
            if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (do_push && !do_pop) cnt_q <= cnt_q + 1'b1;
            else if (do_pop && !do_push) cnt_q <= cnt_q - 1'b1;
        end
    end

    // Only the seed entry is written on reset
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) mem_q[0] <= energy_max_c;
        else if (do_push) mem_q[wr_ptr_q] <= wr_data;
    end

endmodule

//--- hdl/energy_fifo_maintainer.sv
/*
 * Energy FIFO maintainer
 * Holds the candidate spin, compares its energy with the stored best and
 * releases the spin downstream with a worse (push-none) flag
 */

`timescale 1ns/1ps

module energy_fifo_maintainer #(
    parameter int NUM_SPIN = ising_cfg_pkg::num_spin_c,
    parameter int unsigned FIFO_DEPTH = ising_cfg_pkg::fifo_depth_c,
    parameter int unsigned ADDR_DEPTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic flush_i,
    spin_stream_if.dst in,
    output logic out_valid_o,
    output logic [NUM_SPIN-1:0] out_spin_o,
    output logic out_worse_o,
    input  logic out_ready_i,
    output logic signed [ising_cfg_pkg::energy_bit_c-1:0] best_energy_o,
    output logic [ADDR_DEPTH-1:0] usage_o
);
    import ising_cfg_pkg::*;

    logic fifo_full;
    logic fifo_empty;
    logic push_none;
    logic spin_fire;
    logic energy_fire;
    logic out_fire;
    logic signed [energy_bit_c-1:0] energy_head;
    logic [NUM_SPIN-1:0] spin_q;
    logic spin_full_q;
    logic out_valid_q;
    logic worse_q;

    // Pop and push together on every accepted energy
    energy_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .ADDR_DEPTH(ADDR_DEPTH)
    ) i_energy_fifo (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .flush_i(flush_i),
        .push_i(energy_fire),
        .pop_i(energy_fire),
        .push_none_i(push_none),
        .data_i(in.energy),
        .data_o(energy_head),
        .full_o(fifo_full),
        .empty_o(fifo_empty),
        .usage_o(usage_o)
    );

    // Handshakes
    assign in.ready = ~spin_full_q;
    assign in.energy_ready = ~fifo_full;
    assign spin_fire = in.valid & in.ready;
    assign energy_fire = in.energy_valid & in.energy_ready;
    assign out_fire = out_valid_o & out_ready_i;

    // Not an improvement when the energy does not drop below the head
    assign push_none = ~fifo_empty & (in.energy >= energy_head);

    // Spin slot, output valid and worse flag live until the output transfer
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i || out_fire) begin
            spin_full_q <= 1'b0;
            out_valid_q <= 1'b0;
            worse_q <= 1'b0;
        end else begin
            if (spin_fire) spin_full_q <= 1'b1;
            if (energy_fire) begin
                out_valid_q <= 1'b1;
                worse_q <= push_none;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_fire) spin_q <= in.spin;
    end

    assign out_valid_o = out_valid_q;
    assign out_spin_o = spin_q;
    assign out_worse_o = worse_q;
    assign best_energy_o = energy_head;

endmodule

//--- hdl/anneal_step_ctrl.sv
/*
 * Anneal step controller
 * Takes one candidate at a time, runs the accumulator, offers spin and
 * energy to the maintainer and counts accepted steps
 */

`timescale 1ns/1ps

module anneal_step_ctrl #(
    parameter int NUM_SPIN = ising_cfg_pkg::num_spin_c
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic flush_i,
    input  logic cand_valid_i,
    input  logic [NUM_SPIN-1:0] cand_spin_i,
    output logic cand_ready_o,
    output logic accum_start_o,
    output logic [NUM_SPIN-1:0] accum_spin_o,
    input  logic accum_done_i,
    input  logic signed [ising_cfg_pkg::energy_bit_c-1:0] accum_energy_i,
    spin_stream_if.src mnt,
    input  logic out_fire_i,
    input  logic out_worse_i,
    output logic [ising_cfg_pkg::count_bit_c-1:0] accept_count_o
);
    import ising_cfg_pkg::*;
    import ising_types_pkg::*;

    step_state_t state_q;
    step_state_t state_d;
    logic [NUM_SPIN-1:0] spin_q;
    logic spin_sent_q;
    logic cand_fire;
    logic spin_fire;
    logic energy_fire;
    logic [count_bit_c-1:0] count_q;

    // Candidate intake only while idle, accumulator starts on the transfer
    assign cand_ready_o = (state_q == IDLE);
    assign cand_fire = cand_valid_i & cand_ready_o;
    assign accum_start_o = cand_fire;
    assign accum_spin_o = cand_spin_i;

    // Spin offered once during ACCUM, energy in COMPARE
    assign mnt.valid = (state_q == ACCUM) & ~spin_sent_q;
    assign mnt.spin = spin_q;
    assign mnt.energy_valid = (state_q == COMPARE);
    assign mnt.energy = accum_energy_i;
    assign spin_fire = mnt.valid & mnt.ready;
    assign energy_fire = mnt.energy_valid & mnt.energy_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (cand_fire) state_d = ACCUM;
            ACCUM:   if (accum_done_i) state_d = COMPARE;
            COMPARE: if (energy_fire) state_d = HOLD;
            HOLD:    if (out_fire_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            state_q <= IDLE;
            spin_sent_q <= 1'b0;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            if (cand_fire) spin_sent_q <= 1'b0;
            else if (spin_fire) spin_sent_q <= 1'b1;
            // Improving steps only
            if (out_fire_i && !out_worse_i) count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cand_fire) spin_q <= cand_spin_i;
    end

    assign accept_count_o = count_q;

endmodule

//--- hdl/ising_anneal_top.sv
/*
 * Ising anneal candidate checker
 * Field memory, serial energy accumulator, best-energy maintainer and
 * step controller behind plain valid/ready ports
 */

`timescale 1ns/1ps

module ising_anneal_top #(
    parameter int NUM_SPIN = ising_cfg_pkg::num_spin_c,
    parameter int unsigned FIFO_DEPTH = ising_cfg_pkg::fifo_depth_c,
    parameter int unsigned IDX_BIT = (NUM_SPIN > 1) ? $clog2(NUM_SPIN) : 1,
    parameter int unsigned ADDR_DEPTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic flush_i,
    input  logic field_we_i,
    input  logic [IDX_BIT-1:0] field_waddr_i,
    input  logic signed [ising_cfg_pkg::field_bit_c-1:0] field_wdata_i,
    input  logic cand_valid_i,
    input  logic [NUM_SPIN-1:0] cand_spin_i,
    output logic cand_ready_o,
    output logic out_valid_o,
    output logic [NUM_SPIN-1:0] out_spin_o,
    output logic out_worse_o,
    input  logic out_ready_i,
    output logic signed [ising_cfg_pkg::energy_bit_c-1:0] best_energy_o,
    output logic [ising_cfg_pkg::count_bit_c-1:0] accept_count_o,
    output logic [ADDR_DEPTH-1:0] usage_o
);
    import ising_cfg_pkg::*;

    logic accum_start;
    logic [NUM_SPIN-1:0] accum_spin;
    logic accum_done;
    logic signed [energy_bit_c-1:0] accum_energy;
    logic [IDX_BIT-1:0] field_addr;
    logic signed [field_bit_c-1:0] field_rdata;
    logic out_fire;

    spin_stream_if #(.NUM_SPIN(NUM_SPIN)) mnt_if ();

    // Output transfer, seen by the controller for return to IDLE
    assign out_fire = out_valid_o & out_ready_i;

    field_mem #(.NUM_SPIN(NUM_SPIN), .IDX_BIT(IDX_BIT)) i_field_mem (
        .clk_i(clk_i), .rst_i(rst_i), .we_i(field_we_i), .waddr_i(field_waddr_i),
        .wdata_i(field_wdata_i), .raddr_i(field_addr), .rdata_o(field_rdata)
    );

    energy_accum #(.NUM_SPIN(NUM_SPIN), .IDX_BIT(IDX_BIT)) i_energy_accum (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(accum_start), .spin_i(accum_spin),
        .field_addr_o(field_addr), .field_i(field_rdata), .done_o(accum_done),
        .energy_o(accum_energy)
    );

    energy_fifo_maintainer #(
        .NUM_SPIN(NUM_SPIN), .FIFO_DEPTH(FIFO_DEPTH), .ADDR_DEPTH(ADDR_DEPTH)
    ) i_energy_fifo_maintainer (
        .clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i), .in(mnt_if.dst),
        .out_valid_o(out_valid_o), .out_spin_o(out_spin_o), .out_worse_o(out_worse_o),
        .out_ready_i(out_ready_i), .best_energy_o(best_energy_o), .usage_o(usage_o)
    );

    anneal_step_ctrl #(.NUM_SPIN(NUM_SPIN)) i_anneal_step_ctrl (
        .clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i),
        .cand_valid_i(cand_valid_i), .cand_spin_i(cand_spin_i), .cand_ready_o(cand_ready_o),
        .accum_start_o(accum_start), .accum_spin_o(accum_spin), .accum_done_i(accum_done),
        .accum_energy_i(accum_energy), .mnt(mnt_if.src), .out_fire_i(out_fire),
        .out_worse_i(out_worse_o), .accept_count_o(accept_count_o)
    );

endmodule

//--- test/ising_anneal_asserts.sv
/*
 * Ising anneal port checks
 * Reset and flush values, output latency, spin pass-through,
 * back-pressure stability and the first result after a clear
 */

`timescale 1ns/1ps

module ising_anneal_asserts #(
    parameter int NUM_SPIN = ising_cfg_pkg::num_spin_c
) (
    input logic clk_i,
    input logic rst_i,
    input logic flush_i,
    input logic cand_valid_i,
    input logic [NUM_SPIN-1:0] cand_spin_i,
    input logic cand_ready_o,
    input logic out_valid_o,
    input logic [NUM_SPIN-1:0] out_spin_o,
    input logic out_worse_o,
    input logic out_ready_i,
    input logic signed [ising_cfg_pkg::energy_bit_c-1:0] best_energy_o,
    input logic [ising_cfg_pkg::count_bit_c-1:0] accept_count_o
);
    import ising_cfg_pkg::*;
    import ising_types_pkg::*;

    // Candidate transfer to output valid
    localparam int lat_c = NUM_SPIN + 2;

    int fail_count;
    logic cand_fire;
    logic [NUM_SPIN-1:0] last_cand_q;
    // Set until the first output after reset or flush
    logic fresh_q;

    initial fail_count = 0;

    assign cand_fire = cand_valid_i & cand_ready_o;

    always_ff @(posedge clk_i) begin
        if (cand_fire) begin
            last_cand_q <= cand_spin_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            fresh_q <= 1'b1;
        end else if (out_valid_o && out_ready_i) begin
            fresh_q <= 1'b0;
        end
    end

    // Reset and flush values
    a_clear_valid: assert property (@(posedge clk_i)
        (rst_i || flush_i) |=> !out_valid_o && !out_worse_o && cand_ready_o)
    else begin
        $error("ERR %0t out_valid_o/out_worse_o/cand_ready_o got %b%b%b exp 001", $time,
            $sampled(out_valid_o), $sampled(out_worse_o), $sampled(cand_ready_o));
        fail_count++;
    end

    a_clear_count: assert property (@(posedge clk_i)
        (rst_i || flush_i) |=> accept_count_o == '0)
    else begin
        $error("ERR %0t accept_count_o got %0d exp 0", $time, $sampled(accept_count_o));
        fail_count++;
    end

    a_clear_best: assert property (@(posedge clk_i)
        (rst_i || flush_i) |=> best_energy_o == energy_max_c)
    else begin
        $error("ERR %0t best_energy_o got %0d exp %0d", $time,
            $sampled(best_energy_o), energy_max_c);
        fail_count++;
    end

    // Output valid exactly lat_c cycles after the transfer
    a_out_latency: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
        cand_fire |-> ##1 !out_valid_o [*lat_c] ##1 out_valid_o)
    else begin
        $error("Output valid did not rise exactly NUM_SPIN+2 cycles after a candidate");
        fail_count++;
    end

    a_out_spin: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
        out_valid_o |-> out_spin_o == last_cand_q)
    else begin
        $error("ERR %0t out_spin_o got %h exp %h", $time,
            $sampled(out_spin_o), $sampled(last_cand_q));
        fail_count++;
    end

    // Back-pressure keeps the output steady
    a_hold_steady: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_spin_o) && $stable(out_worse_o))
    else begin
        $error("Output changed while out_ready_i was low");
        fail_count++;
    end

    a_no_intake: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
        out_valid_o |-> !cand_ready_o)
    else begin
        $error("ERR %0t cand_ready_o got 1 exp 0", $time);
        fail_count++;
    end

    // Ceiling as best, so the first candidate always improves
    a_first_better: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
        out_valid_o && fresh_q |-> !out_worse_o)
    else begin
        $error("ERR %0t out_worse_o got 1 exp 0", $time);
        fail_count++;
    end

endmodule

//--- test/tb_ising_anneal.sv
/*
 * Ising anneal testbench
 * Loads random fields, offers random candidates with random output stalls,
 * models energy and running best, flushes and runs on
 */

`timescale 1ns/1ps

module tb_ising_anneal;
    import ising_cfg_pkg::*;
    import ising_types_pkg::*;

    localparam int NUM_SPIN = num_spin_c;
    localparam int idx_bit_c = $clog2(NUM_SPIN);
    localparam int seed_c = 63;
    localparam int cand_count_c = 40;
    // Candidates run before the flush
    localparam int flush_after_c = 30;
    // Worst case per candidate plus the reset
    localparam int timeout_cycles_c = cand_count_c * (NUM_SPIN + 10) + 16;

    logic clk_i;
    logic rst_i;
    logic flush_i;
    logic field_we_i;
    logic [idx_bit_c-1:0] field_waddr_i;
    logic signed [field_bit_c-1:0] field_wdata_i;
    logic cand_valid_i;
    logic [NUM_SPIN-1:0] cand_spin_i;
    logic cand_ready_o;
    logic out_valid_o;
    logic [NUM_SPIN-1:0] out_spin_o;
    logic out_worse_o;
    logic out_ready_i;
    logic signed [energy_bit_c-1:0] best_energy_o;
    logic [count_bit_c-1:0] accept_count_o;
    logic [$clog2(fifo_depth_c)-1:0] usage_o;

    // Model state
    int field_w [NUM_SPIN];
    int best_exp;
    int acc_exp;
    int err_count;
    int check_count;
    int cycle_count;
    logic [15:0] lfsr_q;

    ising_anneal_top #(.NUM_SPIN(NUM_SPIN)) i_ising_anneal_top (.*);

    bind ising_anneal_top ising_anneal_asserts #(.NUM_SPIN(NUM_SPIN)) i_ising_anneal_asserts (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles_c) begin
            $display("Timeout after %0d cycles, the DUT did not finish", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = next_lfsr(lfsr_q);
            bits = {bits[30:0], lfsr_q[0]};
        end
        return bits;
    endfunction

    // Set spin adds its field, clear spin subtracts it
    function automatic int spin_energy(input logic [NUM_SPIN-1:0] s);
        int e;
        e = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            e = s[i] ? e + field_w[i] : e - field_w[i];
        end
        return e;
    endfunction

    task automatic compare_value(input string name, input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic step_clock();
        @(posedge clk_i);
        #2;
    endtask

    // One candidate through intake, accumulation, compare and a stalled output
    task automatic run_candidate(input logic [NUM_SPIN-1:0] spin, input int span);
        int energy;
        int worse_exp;
        while (!cand_ready_o) step_clock();
        compare_value("accept_count_o", accept_count_o, acc_exp);
        cand_valid_i = 1'b1;
        cand_spin_i = spin;
        step_clock();
        cand_valid_i = 1'b0;
        energy = spin_energy(spin);
        worse_exp = (energy >= best_exp) ? 1 : 0;
        if (worse_exp == 0) begin
            best_exp = energy;
            acc_exp++;
        end
        while (!out_valid_o) step_clock();
        compare_value("out_worse_o", out_worse_o, worse_exp);
        compare_value("best_energy_o", best_energy_o, best_exp);
        // The FIFO keeps exactly the one best entry
        compare_value("usage_o", usage_o, 1);
        repeat (span) step_clock();
        out_ready_i = 1'b1;
        step_clock();
        out_ready_i = 1'b0;
    endtask

    initial begin
        int total_errors;
        logic [NUM_SPIN-1:0] spin;
        int span;
        rst_i = 1'b1;
        flush_i = 1'b0;
        field_we_i = 1'b0;
        field_waddr_i = '0;
        field_wdata_i = '0;
        cand_valid_i = 1'b0;
        cand_spin_i = '0;
        out_ready_i = 1'b0;
        lfsr_q = 16'(seed_c);
        err_count = 0;
        check_count = 0;
        cycle_count = 0;
        best_exp = energy_max_c;
        acc_exp = 0;
        repeat (16) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        step_clock();
        $display("reset_values: done");

        // One field write per cycle
        for (int i = 0; i < NUM_SPIN; i++) begin
            field_we_i = 1'b1;
            field_waddr_i = idx_bit_c'(i);
            field_wdata_i = field_bit_c'(draw_bits(field_bit_c));
            field_w[i] = field_wdata_i;
            step_clock();
        end
        field_we_i = 1'b0;
        $display("field_load: %0d weights written", NUM_SPIN);

        for (int c = 0; c < cand_count_c; c++) begin
            if (c == flush_after_c) begin
                $display("candidates: %0d run, %0d errors", c, err_count);
                flush_i = 1'b1;
                step_clock();
                flush_i = 1'b0;
                best_exp = energy_max_c;
                acc_exp = 0;
            end
            spin = NUM_SPIN'(draw_bits(NUM_SPIN));
            span = int'(draw_bits(2));
            run_candidate(spin, span);
        end
        compare_value("accept_count_o", accept_count_o, acc_exp);
        repeat (2) step_clock();
        $display("flush: %0d run after flush, %0d errors", cand_count_c - flush_after_c,
            err_count);

        total_errors = err_count + i_ising_anneal_top.i_ising_anneal_asserts.fail_count;
        $display("Checks %0d, check errors %0d, assertion failures %0d", check_count,
            err_count, i_ising_anneal_top.i_ising_anneal_asserts.fail_count);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/ising_cfg_pkg.sv
hdl/ising_types_pkg.sv
hdl/spin_stream_if.sv
hdl/field_mem.sv
hdl/energy_accum.sv
hdl/energy_fifo.sv
hdl/energy_fifo_maintainer.sv
hdl/anneal_step_ctrl.sv
hdl/ising_anneal_top.sv
test/ising_anneal_asserts.sv
test/tb_ising_anneal.sv

//--- Bender.yml
package:
  name: ising_anneal

sources:
  - hdl/ising_cfg_pkg.sv
  - hdl/ising_types_pkg.sv
  - hdl/spin_stream_if.sv
  - hdl/field_mem.sv
  - hdl/energy_accum.sv
  - hdl/energy_fifo.sv
  - hdl/energy_fifo_maintainer.sv
  - hdl/anneal_step_ctrl.sv
  - hdl/ising_anneal_top.sv
  - target: test
    files:
      - test/ising_anneal_asserts.sv
      - test/tb_ising_anneal.sv
